// File: hdl/dnn_pkg.sv
package dnn_pkg;

  // ******************************************************************
  // widths shared by the stream datapath
  // ******************************************************************

  // byte address into the external memory
  localparam int ADDR_W = 16;

  // transfer size field carried with each request
  localparam int SIZE_W = 12;

  // loop count field
  // number of reads per descriptor is loop_max+1
  localparam int LOOP_W = 8;

  // ******************************************************************
  // reduction kind
  // ******************************************************************

  typedef enum logic [0:0] {
    // wrapping sum of returned words
    RED_SUM = 1'b0,
    // unsigned maximum of returned words
    RED_MAX = 1'b1
  } red_type_e;

  // ******************************************************************
  // one read-stream descriptor
  // ******************************************************************

  // 69 bits packed with red_type on top
  typedef struct packed {
    red_type_e           red_type;
    logic [ADDR_W-1:0]   base;
    logic [ADDR_W-1:0]   offset;
    logic [SIZE_W-1:0]   size;
    logic [LOOP_W-1:0]   loop_max;
    logic [ADDR_W-1:0]   out_addr;
  } stream_desc_t;

endpackage

// File: hdl/mem_bus_if.sv
interface mem_bus_if
  import dnn_pkg::*;
#(
  parameter int DATA_W = 32
) ();

  // one requester's view of the shared memory port

  // request side held stable until ready
  logic              req;
  logic              wr;
  logic [ADDR_W-1:0] addr;
  logic [SIZE_W-1:0] size;
  logic [DATA_W-1:0] wdata;

  // response side
  // rdata valid in the ready cycle for reads
  logic              ready;
  logic [DATA_W-1:0] rdata;

  modport requester (
    output req, wr, addr, size, wdata,
    input  ready, rdata
  );

  modport arbiter (
    input  req, wr, addr, size, wdata,
    output ready, rdata
  );

endinterface

// File: hdl/layer_sequencer.sv
module layer_sequencer
  import dnn_pkg::*;
#(
  parameter int DESC_DEPTH = 8
) (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         start,
  input  logic [((DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1):0] num_desc,
  input  logic                                         cfg_we,
  input  logic [((DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1)-1:0] cfg_idx,
  input  stream_desc_t                                 cfg_desc,
  input  logic                                         desc_done,
  output stream_desc_t                                 desc,
  output logic                                         desc_go,
  output logic                                         busy,
  output logic                                         done
);

  // ******************************************************************
  // local widths
  // ******************************************************************

  // index width for the descriptor table
  localparam int IDX_W = (DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1;

  // ******************************************************************
  // descriptor table
  // ******************************************************************

  stream_desc_t desc_table [DESC_DEPTH];

  // current entry and latched count
  logic [IDX_W-1:0] idx;
  logic [IDX_W:0]   idx_next;
  logic [IDX_W:0]   desc_cnt;

  // host writes one entry per cfg_we
  always_ff @(posedge clk)
  begin
    if (cfg_we)
    begin
      desc_table[cfg_idx] <= cfg_desc;
    end
  end

  // entry under the walk pointer
  // valid in the same cycle as desc_go
  assign desc = desc_table[idx];

  // one wider than idx so the end compare cannot wrap
  assign idx_next = {1'b0, idx} + 1'b1;

  // ******************************************************************
  // start / walk / done control
  // ******************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy     <= 1'b0;
      done     <= 1'b0;
      desc_go  <= 1'b0;
      idx      <= '0;
      desc_cnt <= '0;
    end
    else
    begin
      // pulses by default
      desc_go <= 1'b0;
      done    <= 1'b0;
      if (!busy)
      begin
        // start only seen while idle
        if (start)
        begin
          idx      <= '0;
          desc_cnt <= num_desc;
          if (num_desc == '0)
          begin
            // empty table, finish at once
            done <= 1'b1;
          end
          else
          begin
            busy    <= 1'b1;
            desc_go <= 1'b1;
          end
        end
      end
      else if (desc_done)
      begin
        if (idx_next == desc_cnt)
        begin
          // last descriptor written back
          busy <= 1'b0;
          done <= 1'b1;
        end
        else
        begin
          // advance and kick the next entry
          idx     <= idx_next[IDX_W-1:0];
          desc_go <= 1'b1;
        end
      end
    end
  end

  // ******************************************************************
  // checks
  // ******************************************************************

  // writer completion only ever follows a kick from this walk
  a_done_while_busy : assert property (
    @(posedge clk) disable iff (rst)
    desc_done |-> busy
  );

endmodule

// File: hdl/rd_stream_gen.sv
module rd_stream_gen
  import dnn_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              desc_go,
  input  stream_desc_t      desc,
  mem_bus_if.requester      bus,
  output logic              beat_valid,
  output logic [DATA_W-1:0] beat_data,
  output logic              beat_last
);

  // ******************************************************************
  // state
  // ******************************************************************

  // high while reads remain for this descriptor
  logic              active;
  // reads accepted so far
  logic [LOOP_W-1:0] rd_cnt;

  // descriptor fields held for the whole stream
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] rd_offset;
  logic [SIZE_W-1:0] rd_size;
  logic [LOOP_W-1:0] rd_loop_max;

  logic rd_accept;
  logic rd_final;

  assign rd_accept = active && bus.ready;
  assign rd_final  = (rd_cnt == rd_loop_max);

  // ******************************************************************
  // request control
  // ******************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      active     <= 1'b0;
      rd_cnt     <= '0;
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end
    else
    begin
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
      if (desc_go)
      begin
        active <= 1'b1;
        rd_cnt <= '0;
      end
      else if (rd_accept)
      begin
        // one beat per returned word
        beat_valid <= 1'b1;
        beat_last  <= rd_final;
        rd_cnt     <= rd_cnt + 1'b1;
        if (rd_final)
        begin
          active <= 1'b0;
        end
      end
    end
  end

  // address walk and payload capture
  always_ff @(posedge clk)
  begin
    if (desc_go)
    begin
      rd_addr     <= desc.base;
      rd_offset   <= desc.offset;
      rd_size     <= desc.size;
      rd_loop_max <= desc.loop_max;
    end
    else if (rd_accept)
    begin
      // stride wraps at ADDR_W
      rd_addr <= rd_addr + rd_offset;
    end
    if (rd_accept)
    begin
      beat_data <= bus.rdata;
    end
  end

  // ******************************************************************
  // bus drive
  // ******************************************************************

  assign bus.req   = active;
  assign bus.wr    = 1'b0;
  assign bus.addr  = rd_addr;
  assign bus.size  = rd_size;
  assign bus.wdata = '0;

  // held request keeps its address until the arbiter answers
  a_addr_hold : assert property (
    @(posedge clk) disable iff (rst)
    (bus.req && !bus.ready) |=> (bus.req && $stable(bus.addr))
  );

endmodule

// File: hdl/acc_writer.sv
module acc_writer
  import dnn_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              desc_go,
  input  stream_desc_t      desc,
  input  logic              beat_valid,
  input  logic [DATA_W-1:0] beat_data,
  input  logic              beat_last,
  mem_bus_if.requester      bus,
  output logic              desc_done
);

  // ******************************************************************
  // state
  // ******************************************************************

  // next beat loads rather than combines
  logic              first_beat;
  // result write outstanding
  logic              wr_pend;

  // per-descriptor settings
  red_type_e         red_type_q;
  logic [ADDR_W-1:0] out_addr_q;

  logic [DATA_W-1:0] acc;
  logic [DATA_W-1:0] acc_next;

  // ******************************************************************
  // reduction
  // ******************************************************************

  always_comb
  begin
    if (first_beat)
    begin
      acc_next = beat_data;
    end
    else if (red_type_q == RED_MAX)
    begin
      // unsigned compare
      acc_next = (beat_data > acc) ? beat_data : acc;
    end
    else
    begin
      // sum wraps at DATA_W
      acc_next = acc + beat_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (desc_go)
    begin
      red_type_q <= desc.red_type;
      out_addr_q <= desc.out_addr;
    end
    if (beat_valid)
    begin
      acc <= acc_next;
    end
  end

  // ******************************************************************
  // write control
  // ******************************************************************

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      first_beat <= 1'b0;
      wr_pend    <= 1'b0;
    end
    else
    begin
      if (desc_go)
      begin
        first_beat <= 1'b1;
      end
      else if (beat_valid)
      begin
        first_beat <= 1'b0;
      end
      // write goes out the cycle after the closing beat
      if (beat_valid && beat_last)
      begin
        wr_pend <= 1'b1;
      end
      else if (bus.ready)
      begin
        wr_pend <= 1'b0;
      end
    end
  end

  // completion in the ready cycle itself
  assign desc_done = wr_pend && bus.ready;

  // single-word write of the result
  assign bus.req   = wr_pend;
  assign bus.wr    = 1'b1;
  assign bus.addr  = out_addr_q;
  assign bus.size  = SIZE_W'(1);
  assign bus.wdata = acc;

endmodule

// File: hdl/mem_arbiter.sv
module mem_arbiter
  import dnn_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst,
  mem_bus_if.arbiter        rd_bus,
  mem_bus_if.arbiter        wr_bus,
  input  logic              mem_ready,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              mem_req,
  output logic              mem_wr,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [SIZE_W-1:0] mem_size,
  output logic [DATA_W-1:0] mem_wdata
);

  // ******************************************************************
  // grant selection
  // ******************************************************************

  // grant held from an earlier cycle
  logic lock_valid;
  logic lock_wr;
  // current grant, high selects the writer
  logic sel_wr;

  always_comb
  begin
    if (lock_valid)
    begin
      sel_wr = lock_wr;
    end
    else
    begin
      // pending write wins
      sel_wr = wr_bus.req;
    end
  end

  // lock while the granted request waits on the memory
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      lock_valid <= 1'b0;
      lock_wr    <= 1'b0;
    end
    else
    begin
      lock_valid <= mem_req && !mem_ready;
      lock_wr    <= sel_wr;
    end
  end

  // ******************************************************************
  // port mux and response routing
  // ******************************************************************

  assign mem_req   = sel_wr ? wr_bus.req   : rd_bus.req;
  assign mem_wr    = sel_wr ? wr_bus.wr    : rd_bus.wr;
  assign mem_addr  = sel_wr ? wr_bus.addr  : rd_bus.addr;
  assign mem_size  = sel_wr ? wr_bus.size  : rd_bus.size;
  assign mem_wdata = sel_wr ? wr_bus.wdata : rd_bus.wdata;

  // answer only the granted side
  assign rd_bus.ready = mem_ready && mem_req && !sel_wr;
  assign wr_bus.ready = mem_ready && mem_req && sel_wr;
  assign rd_bus.rdata = sel_wr ? '0 : mem_rdata;
  assign wr_bus.rdata = sel_wr ? mem_rdata : '0;

  // ******************************************************************
  // checks
  // ******************************************************************

  a_grant_locked : assert property (
    @(posedge clk) disable iff (rst)
    (mem_req && !mem_ready) |=> (mem_req && (sel_wr == $past(sel_wr)))
  );

  a_one_ready : assert property (
    @(posedge clk) disable iff (rst)
    !(rd_bus.ready && wr_bus.ready)
  );

endmodule

// File: hdl/dnn_stream_top.sv
module dnn_stream_top
  import dnn_pkg::*;
#(
  parameter int DATA_W     = 32,
  parameter int DESC_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [((DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1):0] num_desc,
  output logic              busy,
  output logic              done,
  // descriptor table load
  input  logic              cfg_we,
  input  logic [((DESC_DEPTH > 1) ? $clog2(DESC_DEPTH) : 1)-1:0] cfg_idx,
  input  red_type_e         cfg_red_type,
  input  logic [ADDR_W-1:0] cfg_base,
  input  logic [ADDR_W-1:0] cfg_offset,
  input  logic [SIZE_W-1:0] cfg_size,
  input  logic [LOOP_W-1:0] cfg_loop_max,
  input  logic [ADDR_W-1:0] cfg_out_addr,
  // external memory port
  output logic              mem_req,
  output logic              mem_wr,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [SIZE_W-1:0] mem_size,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic              mem_ready,
  input  logic [DATA_W-1:0] mem_rdata
);

  // ******************************************************************
  // internal wiring
  // ******************************************************************

  stream_desc_t      desc;
  logic              desc_go;
  logic              desc_done;
  logic              beat_valid;
  logic [DATA_W-1:0] beat_data;
  logic              beat_last;

  // reader and writer views of the memory port
  mem_bus_if #(.DATA_W(DATA_W)) rd_bus ();
  mem_bus_if #(.DATA_W(DATA_W)) wr_bus ();

  // ******************************************************************
  // instances
  // ******************************************************************

  // cfg fields packed in descriptor field order
  layer_sequencer #(
    .DESC_DEPTH (DESC_DEPTH)
  ) u_seq (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .num_desc  (num_desc),
    .cfg_we    (cfg_we),
    .cfg_idx   (cfg_idx),
    .cfg_desc  ({cfg_red_type, cfg_base, cfg_offset, cfg_size, cfg_loop_max, cfg_out_addr}),
    .desc_done (desc_done),
    .desc      (desc),
    .desc_go   (desc_go),
    .busy      (busy),
    .done      (done)
  );

  rd_stream_gen #(
    .DATA_W (DATA_W)
  ) u_rd (
    .clk        (clk),
    .rst        (rst),
    .desc_go    (desc_go),
    .desc       (desc),
    .bus        (rd_bus.requester),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last)
  );

  acc_writer #(
    .DATA_W (DATA_W)
  ) u_acc (
    .clk        (clk),
    .rst        (rst),
    .desc_go    (desc_go),
    .desc       (desc),
    .beat_valid (beat_valid),
    .beat_data  (beat_data),
    .beat_last  (beat_last),
    .bus        (wr_bus.requester),
    .desc_done  (desc_done)
  );

  mem_arbiter #(
    .DATA_W (DATA_W)
  ) u_arb (
    .clk       (clk),
    .rst       (rst),
    .rd_bus    (rd_bus.arbiter),
    .wr_bus    (wr_bus.arbiter),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .mem_req   (mem_req),
    .mem_wr    (mem_wr),
    .mem_addr  (mem_addr),
    .mem_size  (mem_size),
    .mem_wdata (mem_wdata)
  );

endmodule

// File: dv/dnn_stream_tb.sv
module dnn_stream_tb
  import dnn_pkg::*;
();

  localparam int DATA_W     = 32;
  localparam int DESC_DEPTH = 8;
  localparam int IDX_W      = 3;
  localparam int NUM_W      = IDX_W + 1;
  localparam int CLK_PERIOD = 40;
  // worst walk is 256 reads at up to 5 cycles each
  localparam int MAX_CYCLES = 4000;

  logic              clk;
  logic              rst;
  logic              start;
  logic [NUM_W-1:0]  num_desc;
  logic              busy;
  logic              done;
  logic              cfg_we;
  logic [IDX_W-1:0]  cfg_idx;
  red_type_e         cfg_red_type;
  logic [ADDR_W-1:0] cfg_base;
  logic [ADDR_W-1:0] cfg_offset;
  logic [SIZE_W-1:0] cfg_size;
  logic [LOOP_W-1:0] cfg_loop_max;
  logic [ADDR_W-1:0] cfg_out_addr;
  logic              mem_req;
  logic              mem_wr;
  logic [ADDR_W-1:0] mem_addr;
  logic [SIZE_W-1:0] mem_size;
  logic [DATA_W-1:0] mem_wdata;
  logic              mem_ready;
  logic [DATA_W-1:0] mem_rdata;

  // transfers logged by the memory model
  logic [ADDR_W-1:0] rd_addr_q [$];
  logic [SIZE_W-1:0] rd_size_q [$];
  logic [ADDR_W-1:0] wr_addr_q [$];
  logic [DATA_W-1:0] wr_data_q [$];
  logic [SIZE_W-1:0] wr_size_q [$];
  // time the latest write got its mem_ready
  time               wr_ready_t;

  // current case from the file
  string             case_name;
  int                case_num;
  int                desc_cnt;
  int                exp_cnt;
  logic              d_rt     [DESC_DEPTH];
  logic [ADDR_W-1:0] d_base   [DESC_DEPTH];
  logic [ADDR_W-1:0] d_off    [DESC_DEPTH];
  logic [SIZE_W-1:0] d_size   [DESC_DEPTH];
  logic [LOOP_W-1:0] d_lm     [DESC_DEPTH];
  logic [ADDR_W-1:0] d_out    [DESC_DEPTH];
  logic [ADDR_W-1:0] e_addr   [DESC_DEPTH];
  logic [DATA_W-1:0] e_data   [DESC_DEPTH];

  int err_cnt;
  int case_cnt;
  int bad_case_cnt;
  bit stalled;

  dnn_stream_top #(
    .DATA_W     (DATA_W),
    .DESC_DEPTH (DESC_DEPTH)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .num_desc     (num_desc),
    .busy         (busy),
    .done         (done),
    .cfg_we       (cfg_we),
    .cfg_idx      (cfg_idx),
    .cfg_red_type (cfg_red_type),
    .cfg_base     (cfg_base),
    .cfg_offset   (cfg_offset),
    .cfg_size     (cfg_size),
    .cfg_loop_max (cfg_loop_max),
    .cfg_out_addr (cfg_out_addr),
    .mem_req      (mem_req),
    .mem_wr       (mem_wr),
    .mem_addr     (mem_addr),
    .mem_size     (mem_size),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ******************************************************************
  // helpers
  // ******************************************************************

  // memory contents follow addr*3+1
  function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
    return DATA_W'(32'(addr) * 32'd3 + 32'd1);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act)
    begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // ******************************************************************
  // memory model with one mem_ready pulse per request
  // ******************************************************************

  initial
  begin : mem_model
    int unsigned       dly;
    logic              held_wr;
    logic [ADDR_W-1:0] held_addr;
    logic [SIZE_W-1:0] held_size;
    logic [DATA_W-1:0] held_wdata;
    void'($urandom(94));
    mem_ready  = 1'b0;
    mem_rdata  = '0;
    wr_ready_t = 0;
    forever
    begin
      @(negedge clk);
      mem_ready = 1'b0;
      if (!rst && mem_req)
      begin
        held_wr    = mem_wr;
        held_addr  = mem_addr;
        held_size  = mem_size;
        held_wdata = mem_wdata;
        // random back-pressure
        dly = $urandom_range(3, 0);
        while (dly > 0)
        begin
          @(negedge clk);
          // request must stay put until answered
          if (!mem_req || mem_wr != held_wr || mem_addr != held_addr ||
              mem_size != held_size || (held_wr && mem_wdata != held_wdata))
          begin
            $display("request at %h dropped or changed before mem_ready, t=%0t",
                     held_addr, $time);
            err_cnt++;
          end
          dly--;
        end
        if (held_wr)
        begin
          wr_addr_q.push_back(held_addr);
          wr_data_q.push_back(held_wdata);
          wr_size_q.push_back(held_size);
          mem_rdata  = '0;
          wr_ready_t = $time;
        end
        else
        begin
          rd_addr_q.push_back(held_addr);
          rd_size_q.push_back(held_size);
          mem_rdata = read_word(held_addr);
        end
        mem_ready = 1'b1;
      end
    end
  end

  // ******************************************************************
  // one case loads the table, starts, waits and compares
  // ******************************************************************

  task automatic run_case();
    int                errs_before;
    int                cyc;
    int                exp_reads;
    logic [ADDR_W-1:0] exp_addr;
    errs_before = err_cnt;
    rd_addr_q.delete();
    rd_size_q.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    wr_size_q.delete();
    // one table write per cycle
    for (int i = 0; i < desc_cnt; i++)
    begin
      cfg_we       = 1'b1;
      cfg_idx      = IDX_W'(i);
      cfg_red_type = red_type_e'(d_rt[i]);
      cfg_base     = d_base[i];
      cfg_offset   = d_off[i];
      cfg_size     = d_size[i];
      cfg_loop_max = d_lm[i];
      cfg_out_addr = d_out[i];
      @(negedge clk);
    end
    cfg_we   = 1'b0;
    start    = 1'b1;
    num_desc = NUM_W'(desc_cnt);
    @(negedge clk);
    start = 1'b0;
    // no read request yet one cycle after the start edge
    compare_value("mem_req", 32'd0, 32'(mem_req));
    cyc   = 0;
    while (!busy && cyc < 10)
    begin
      @(negedge clk);
      cyc++;
    end
    if (!busy)
    begin
      $display("timeout: busy never rose after start in case %s", case_name);
      err_cnt++;
      stalled = 1'b1;
      return;
    end
    // a second start mid-walk has to be ignored
    start    = 1'b1;
    num_desc = NUM_W'(1);
    @(negedge clk);
    start = 1'b0;
    // first read request two cycles after the start edge
    if (cyc == 0)
    begin
      compare_value("mem_req", 32'd1, 32'(mem_req));
    end
    cyc   = 0;
    while (!done && cyc < MAX_CYCLES)
    begin
      @(negedge clk);
      cyc++;
    end
    if (!done)
    begin
      $display("timeout: done never pulsed in case %s", case_name);
      err_cnt++;
      stalled = 1'b1;
      return;
    end
    // done one cycle after the last write's mem_ready
    compare_value("done delay", 32'(CLK_PERIOD), 32'($time - wr_ready_t));
    // quiet after the done pulse
    repeat (4)
    begin
      @(negedge clk);
      compare_value("done", 32'd0, 32'(done));
      compare_value("busy", 32'd0, 32'(busy));
      compare_value("mem_req", 32'd0, 32'(mem_req));
    end
    // read stream per descriptor in table order
    exp_reads = 0;
    for (int d = 0; d < desc_cnt; d++)
    begin
      exp_reads += int'(d_lm[d]) + 1;
    end
    compare_value("read count", 32'(exp_reads), 32'(rd_addr_q.size()));
    for (int d = 0; d < desc_cnt; d++)
    begin
      for (int k = 0; k <= int'(d_lm[d]); k++)
      begin
        if (rd_addr_q.size() != 0)
        begin
          // stride wraps at ADDR_W
          exp_addr = d_base[d] + ADDR_W'(k * int'(d_off[d]));
          compare_value("mem_addr (read)", 32'(exp_addr), 32'(rd_addr_q.pop_front()));
          compare_value("mem_size (read)", 32'(d_size[d]), 32'(rd_size_q.pop_front()));
        end
      end
    end
    // result writes
    compare_value("write count", 32'(exp_cnt), 32'(wr_addr_q.size()));
    for (int w = 0; w < exp_cnt; w++)
    begin
      if (wr_addr_q.size() != 0)
      begin
        compare_value("mem_addr (write)", 32'(e_addr[w]), 32'(wr_addr_q.pop_front()));
        compare_value("mem_wdata", e_data[w], wr_data_q.pop_front());
        compare_value("mem_size (write)", 32'd1, 32'(wr_size_q.pop_front()));
      end
    end
    case_cnt++;
    if (err_cnt != errs_before)
    begin
      bad_case_cnt++;
    end
    $display("case %-14s descriptors %0d reads %0d writes %0d errors %0d",
             case_name, desc_cnt, exp_reads, exp_cnt, err_cnt - errs_before);
  endtask

  // ******************************************************************
  // main sequence
  // ******************************************************************

  initial
  begin : main
    int          fd;
    int          n;
    string       line;
    string       kw;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] f5;
    err_cnt      = 0;
    case_cnt     = 0;
    bad_case_cnt = 0;
    stalled      = 1'b0;
    rst          = 1'b1;
    start        = 1'b0;
    num_desc     = '0;
    cfg_we       = 1'b0;
    cfg_idx      = '0;
    cfg_red_type = RED_SUM;
    cfg_base     = '0;
    cfg_offset   = '0;
    cfg_size     = '0;
    cfg_loop_max = '0;
    cfg_out_addr = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    // idle state out of reset
    compare_value("mem_req", 32'd0, 32'(mem_req));
    compare_value("done", 32'd0, 32'(done));
    compare_value("busy", 32'd0, 32'(busy));
    fd = $fopen("dv/stream_cases.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the case file dv/stream_cases.txt");
      err_cnt++;
    end
    else
    begin
      while (!$feof(fd) && !stalled)
      begin
        line = "";
        if ($fgets(line, fd) == 0)
        begin
          break;
        end
        n = $sscanf(line, "%s", kw);
        // blank and comment lines
        if (n < 1 || kw == "#")
        begin
          continue;
        end
        if (kw == "case")
        begin
          n        = $sscanf(line, "%s %s %d", kw, case_name, case_num);
          desc_cnt = 0;
          exp_cnt  = 0;
        end
        else if (kw == "desc" && desc_cnt < DESC_DEPTH)
        begin
          n = $sscanf(line, "%s %h %h %h %h %h %h", kw, f0, f1, f2, f3, f4, f5);
          d_rt[desc_cnt]   = f0[0];
          d_base[desc_cnt] = f1[ADDR_W-1:0];
          d_off[desc_cnt]  = f2[ADDR_W-1:0];
          d_size[desc_cnt] = f3[SIZE_W-1:0];
          d_lm[desc_cnt]   = f4[LOOP_W-1:0];
          d_out[desc_cnt]  = f5[ADDR_W-1:0];
          desc_cnt++;
        end
        else if (kw == "exp" && exp_cnt < DESC_DEPTH)
        begin
          n = $sscanf(line, "%s %h %h", kw, f0, f1);
          e_addr[exp_cnt] = f0[ADDR_W-1:0];
          e_data[exp_cnt] = f1[DATA_W-1:0];
          exp_cnt++;
        end
        else if (kw == "end")
        begin
          if (desc_cnt != case_num)
          begin
            $display("case %s lists %0d descriptors but declares %0d",
                     case_name, desc_cnt, case_num);
            err_cnt++;
          end
          run_case();
        end
      end
      $fclose(fd);
    end
    if (case_cnt == 0)
    begin
      $display("no test case was run");
      err_cnt++;
    end
    $display("cases run %0d, cases with errors %0d, errors %0d",
             case_cnt, bad_case_cnt, err_cnt);
    if (err_cnt == 0 && !stalled)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: list.f
hdl/dnn_pkg.sv
hdl/mem_bus_if.sv
hdl/layer_sequencer.sv
hdl/rd_stream_gen.sv
hdl/acc_writer.sv
hdl/mem_arbiter.sv
hdl/dnn_stream_top.sv
dv/dnn_stream_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = dnn_stream_tb
FILELIST = list.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/stream_cases.txt
# case <name> <num_desc>, one desc line per table entry, exp lines in table order, end
# desc <red_type 0=sum 1=max> <base> <offset> <size> <loop_max> <out_addr>, exp <addr> <data>, hex
case sum_single 1
desc 0 0010 0004 004 03 0100
exp 0100 0000010c
end
case max_wrap 1
desc 1 fff0 0008 008 03 0300
exp 0300 0002ffe9
end
case multi_walk 3
desc 0 0000 0000 001 00 0400
desc 1 0100 0002 002 01 0404
desc 0 0080 0000 003 04 0408
exp 0400 00000001
exp 0404 00000307
exp 0408 00000785
end
case long_sum 1
desc 0 1000 0001 010 ff 0500
exp 0500 00317f80
end
case max_then_sum 2
desc 1 0040 fffc 004 02 0600
desc 0 0002 0003 001 01 0602
exp 0600 000000c1
exp 0602 00000017
end
